/* common/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;  // one strobe bit per byte lane
  localparam int RESP_W = 2;

  typedef logic [ADDR_W-1:0] addr_t;  // byte address
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [RESP_W-1:0] resp_t;

  // EXOKAY and DECERR are never returned by this slave
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* common/sram_pkg.sv */
`default_nettype none

package sram_pkg;

  localparam int BYTE_W = 8;

  typedef logic [BYTE_W-1:0] byte_t;

  // same 32 bits seen as a whole word or as byte lanes
  typedef union packed {
    axi_pkg::data_t                   word;
    byte_t [axi_pkg::STRB_W-1:0]      bytes;  // bytes[0] is the low lane
  } data_word_u;

endpackage

`default_nettype wire

/* common/sram_if.sv */
`default_nettype none

interface sram_if;

  logic           req;      // one-cycle access strobe
  logic           we;
  axi_pkg::addr_t addr;
  axi_pkg::data_t wdata;
  axi_pkg::strb_t wstrb;

  logic           rd_done;  // read completion strobe
  axi_pkg::data_t rdata;
  logic           rd_err;
  logic           wr_done;  // write completion strobe
  logic           wr_err;

  logic           rd_free;  // R handshake seen
  logic           wr_free;  // B handshake seen

  modport front (output req, we, addr, wdata, wstrb, input rd_free, wr_free);

  modport core (input req, we, addr, wdata, wstrb,
                output rd_done, rdata, rd_err, wr_done, wr_err);

  modport back (input rd_done, rdata, rd_err, wr_done, wr_err,
                output rd_free, wr_free);

endinterface

`default_nettype wire

/* logic/axi_req_front.sv */
`default_nettype none

module axi_req_front (
  input  wire                 aclk,
  input  wire                 areset,
  input  wire axi_pkg::addr_t araddr,
  input  wire                 arvalid,
  output logic                arready,
  input  wire axi_pkg::addr_t awaddr,
  input  wire                 awvalid,
  output logic                awready,
  input  wire axi_pkg::data_t wdata,
  input  wire axi_pkg::strb_t wstrb,
  input  wire                 wvalid,
  output logic                wready,
  sram_if.front               bus
);

  axi_pkg::addr_t ar_addr;
  axi_pkg::addr_t aw_addr;
  axi_pkg::data_t w_data;
  axi_pkg::strb_t w_strb;

  logic rd_busy;    // read slot occupied until rd_free
  logic rd_issued;
  logic aw_held;
  logic w_held;
  logic wr_issued;
  logic req_q;
  logic we_q;

  logic ar_hs;
  logic aw_hs;
  logic w_hs;
  logic rd_want;
  logic wr_want;

  assign ar_hs   = arvalid && arready;
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  assign rd_want = rd_busy && !rd_issued;
  assign wr_want = aw_held && w_held && !wr_issued;  // needs both halves

  // slot payloads, held until the slot is released
  always_ff @(posedge aclk) begin
    if (ar_hs) ar_addr <= araddr;
    if (aw_hs) aw_addr <= awaddr;
    if (w_hs) begin
      w_data <= wdata;
      w_strb <= wstrb;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      arready   <= 1'b0;
      awready   <= 1'b0;
      wready    <= 1'b0;
      rd_busy   <= 1'b0;
      rd_issued <= 1'b0;
      aw_held   <= 1'b0;
      w_held    <= 1'b0;
      wr_issued <= 1'b0;
      req_q     <= 1'b0;
      we_q      <= 1'b0;
    end else begin
      arready <= !(ar_hs || (rd_busy && !bus.rd_free));
      awready <= !(aw_hs || (aw_held && !bus.wr_free));
      wready  <= !(w_hs || (w_held && !bus.wr_free));

      if (ar_hs) rd_busy <= 1'b1;
      else if (bus.rd_free) rd_busy <= 1'b0;
      if (aw_hs) aw_held <= 1'b1;
      else if (bus.wr_free) aw_held <= 1'b0;
      if (w_hs) w_held <= 1'b1;
      else if (bus.wr_free) w_held <= 1'b0;

      req_q <= wr_want || rd_want;
      if (wr_want) begin  // write wins a tie
        we_q      <= 1'b1;
        wr_issued <= 1'b1;
      end else if (rd_want) begin
        we_q      <= 1'b0;
        rd_issued <= 1'b1;
      end
      if (bus.rd_free) rd_issued <= 1'b0;
      if (bus.wr_free) wr_issued <= 1'b0;
    end
  end

  assign bus.req   = req_q;
  assign bus.we    = we_q;
  assign bus.addr  = we_q ? aw_addr : ar_addr;  // slots stay put until free
  assign bus.wdata = w_data;
  assign bus.wstrb = w_strb;

endmodule

`default_nettype wire

/* logic/sram_core.sv */
`default_nettype none

module sram_core #(
  parameter int SRAM_READ_CYCLE = 1,
  parameter int MEM_DEPTH_LOG2  = 8
) (
  input  wire   aclk,
  input  wire   areset,
  sram_if.core  bus
);

  localparam int DEPTH = 2 ** MEM_DEPTH_LOG2;

  axi_pkg::data_t mem [DEPTH];

  logic [MEM_DEPTH_LOG2-1:0] req_idx;
  logic                      in_range;

  sram_pkg::data_word_u cur_w;
  sram_pkg::data_word_u in_w;
  sram_pkg::data_word_u merged_w;

  // read delay line, one stage per cycle of latency
  logic                      rd_vld [SRAM_READ_CYCLE];
  logic [MEM_DEPTH_LOG2-1:0] rd_idx [SRAM_READ_CYCLE];
  logic                      rd_bad [SRAM_READ_CYCLE];

  logic wr_done_q;
  logic wr_err_q;

  assign req_idx  = bus.addr[MEM_DEPTH_LOG2+1:2];
  assign in_range = bus.addr[axi_pkg::ADDR_W-1:MEM_DEPTH_LOG2+2] == '0;

  // byte merge under the strobe
  always_comb begin
    cur_w.word = mem[req_idx];
    in_w.word  = bus.wdata;
    merged_w   = cur_w;
    for (int b = 0; b < axi_pkg::STRB_W; b++) begin
      if (bus.wstrb[b]) merged_w.bytes[b] = in_w.bytes[b];
    end
  end

  always_ff @(posedge aclk) begin
    if (bus.req && bus.we && in_range) mem[req_idx] <= merged_w.word;  // out of range dropped
    rd_idx[0] <= req_idx;
    rd_bad[0] <= !in_range;
    wr_err_q  <= !in_range;
    for (int i = 1; i < SRAM_READ_CYCLE; i++) begin
      rd_idx[i] <= rd_idx[i-1];
      rd_bad[i] <= rd_bad[i-1];
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_done_q <= 1'b0;
      for (int i = 0; i < SRAM_READ_CYCLE; i++) rd_vld[i] <= 1'b0;
    end else begin
      wr_done_q <= bus.req && bus.we;
      rd_vld[0] <= bus.req && !bus.we;
      for (int i = 1; i < SRAM_READ_CYCLE; i++) rd_vld[i] <= rd_vld[i-1];
    end
  end

  assign bus.rd_done = rd_vld[SRAM_READ_CYCLE-1];
  assign bus.rd_err  = rd_bad[SRAM_READ_CYCLE-1];
  assign bus.rdata   = rd_bad[SRAM_READ_CYCLE-1] ? '0 : mem[rd_idx[SRAM_READ_CYCLE-1]];
  assign bus.wr_done = wr_done_q;
  assign bus.wr_err  = wr_err_q;

endmodule

`default_nettype wire

/* logic/axi_resp_back.sv */
`default_nettype none

module axi_resp_back (
  input  wire           aclk,
  input  wire           areset,
  output axi_pkg::data_t rdata,
  output axi_pkg::resp_t rresp,
  output logic          rvalid,
  input  wire           rready,
  output axi_pkg::resp_t bresp,
  output logic          bvalid,
  input  wire           bready,
  sram_if.back          bus
);

  logic r_hs;
  logic b_hs;

  assign r_hs = rvalid && rready;
  assign b_hs = bvalid && bready;

  // R and B payloads, loaded once per completion
  always_ff @(posedge aclk) begin
    if (bus.rd_done) begin
      rdata <= bus.rdata;
      rresp <= bus.rd_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
    end
    if (bus.wr_done) begin
      bresp <= bus.wr_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (bus.rd_done) rvalid <= 1'b1;
      else if (r_hs) rvalid <= 1'b0;  // held while rready low

      if (bus.wr_done) bvalid <= 1'b1;
      else if (b_hs) bvalid <= 1'b0;
    end
  end

  // release strobes go back to the front on the handshake itself
  assign bus.rd_free = r_hs;
  assign bus.wr_free = b_hs;

endmodule

`default_nettype wire

/* logic/axi_sram_top.sv */
`default_nettype none

module axi_sram_top #(
  parameter int SRAM_READ_CYCLE = 1,
  parameter int MEM_DEPTH_LOG2  = 8
) (
  input  wire                 aclk,
  input  wire                 areset,
  input  wire axi_pkg::addr_t araddr,
  input  wire                 arvalid,
  output logic                arready,
  output axi_pkg::data_t      rdata,
  output axi_pkg::resp_t      rresp,
  output logic                rvalid,
  input  wire                 rready,
  input  wire axi_pkg::addr_t awaddr,
  input  wire                 awvalid,
  output logic                awready,
  input  wire axi_pkg::data_t wdata,
  input  wire axi_pkg::strb_t wstrb,
  input  wire                 wvalid,
  output logic                wready,
  output axi_pkg::resp_t      bresp,
  output logic                bvalid,
  input  wire                 bready
);

  sram_if bus ();

  axi_req_front i_front (
    .aclk    (aclk),
    .areset  (areset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bus     (bus.front)
  );

  sram_core #(
    .SRAM_READ_CYCLE (SRAM_READ_CYCLE),
    .MEM_DEPTH_LOG2  (MEM_DEPTH_LOG2)
  ) i_core (
    .aclk   (aclk),
    .areset (areset),
    .bus    (bus.core)
  );

  axi_resp_back i_back (
    .aclk   (aclk),
    .areset (areset),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .bus    (bus.back)
  );

endmodule

`default_nettype wire

/* verif/axi_sram_sva.sv */
`default_nettype none

module axi_sram_sva (
  input wire                 aclk,
  input wire                 areset,
  input wire                 arvalid,
  input wire                 arready,
  input wire axi_pkg::data_t rdata,
  input wire axi_pkg::resp_t rresp,
  input wire                 rvalid,
  input wire                 rready,
  input wire axi_pkg::resp_t bresp,
  input wire                 bvalid,
  input wire                 bready
);

  int   err_count;
  logic rd_open;  // AR taken, R not yet taken

  always_ff @(posedge aclk) begin
    if (areset) rd_open <= 1'b0;
    else if (arvalid && arready) rd_open <= 1'b1;
    else if (rvalid && rready) rd_open <= 1'b0;
  end

  r_hold: assert property (@(posedge aclk) disable iff (areset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      err_count++;
      $error("R channel changed before its handshake");
    end

  b_hold: assert property (@(posedge aclk) disable iff (areset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      err_count++;
      $error("B channel changed before its handshake");
    end

  ar_closed: assert property (@(posedge aclk) disable iff (areset) rd_open |-> !arready)
    else begin
      err_count++;
      $error("arready high while a read is in flight");
    end

endmodule

bind axi_sram_top axi_sram_sva i_sva (.*);

`default_nettype wire

/* verif/axi_sram_tb.sv */
`default_nettype none

module axi_sram_tb;

  localparam int DEPTH_LOG2 = 8;
  localparam int TIMEOUT    = 2000;  // about 60 transactions of up to 30 cycles

  logic aclk = 1'b0;
  logic areset = 1'b1;
  logic arvalid = 1'b0, rready = 1'b0, awvalid = 1'b0, wvalid = 1'b0, bready = 1'b0;
  logic arready, rvalid, awready, wready, bvalid;
  axi_pkg::addr_t araddr = '0, awaddr = '0;
  axi_pkg::data_t wdata = '0, rdata, exp_rdata;
  axi_pkg::strb_t wstrb = '0;
  axi_pkg::resp_t rresp, bresp, exp_rresp, exp_bresp;
  axi_pkg::data_t model [2**DEPTH_LOG2];
  axi_pkg::addr_t known [$];  // fully written addresses
  logic r_owed = 1'b0, b_owed = 1'b0;
  logic [31:0] rng = 32'd4;
  int errors, err_mark, n_pass, n_fail, cycles;

  always #10 aclk = ~aclk;

  axi_sram_top #(.SRAM_READ_CYCLE(2), .MEM_DEPTH_LOG2(DEPTH_LOG2)) i_dut (.*);

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic log_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  assert property (@(posedge aclk) areset |=> !(arready || awready || wready || rvalid || bvalid))
    else log_error("a ready or valid was high right after a reset cycle");
  assert property (@(posedge aclk) $fell(areset) |=> arready && awready && wready)
    else log_error("ready signals did not rise after reset");
  assert property (@(posedge aclk) disable iff (areset) rvalid && rready |-> rdata == exp_rdata)
    else log_error($sformatf("[FAIL] rdata expected %h got %h", exp_rdata, $sampled(rdata)));
  assert property (@(posedge aclk) disable iff (areset) rvalid && rready |-> rresp == exp_rresp)
    else log_error($sformatf("[FAIL] rresp expected %h got %h", exp_rresp, $sampled(rresp)));
  assert property (@(posedge aclk) disable iff (areset) bvalid && bready |-> bresp == exp_bresp)
    else log_error($sformatf("[FAIL] bresp expected %h got %h", exp_bresp, $sampled(bresp)));
  assert property (@(posedge aclk) disable iff (areset)
    (!rvalid || r_owed) && (!bvalid || b_owed))
    else log_error("response appeared with no transaction outstanding");

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic addr_ok(input axi_pkg::addr_t addr);
    return addr < 4 * (2 ** DEPTH_LOG2);
  endfunction

  function automatic int total_errors();
    return errors + i_dut.i_sva.err_count;
  endfunction

  task automatic send_aw(input axi_pkg::addr_t addr, input int delay);
    repeat (delay) @(negedge aclk);
    awaddr  = addr;
    awvalid = 1'b1;
    while (!awready) @(negedge aclk);
    @(negedge aclk);
    awvalid = 1'b0;
  endtask

  task automatic send_w(input axi_pkg::data_t data, input axi_pkg::strb_t strb, input int delay);
    repeat (delay) @(negedge aclk);
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    while (!wready) @(negedge aclk);
    @(negedge aclk);
    wvalid = 1'b0;
  endtask

  task automatic write_tx(input axi_pkg::addr_t addr, input axi_pkg::data_t data,
                          input axi_pkg::strb_t strb, input int aw_dly, input int w_dly,
                          input int max_stall);
    int stall;
    stall     = next_rand() % (max_stall + 1);
    exp_bresp = addr_ok(addr) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
    b_owed    = 1'b1;
    for (int b = 0; b < 4; b++) begin
      if (strb[b] && addr_ok(addr)) model[addr[DEPTH_LOG2+1:2]][8*b +: 8] = data[8*b +: 8];
    end
    fork
      send_aw(addr, aw_dly);
      send_w(data, strb, w_dly);
    join
    while (!bvalid) @(negedge aclk);
    repeat (stall) @(negedge aclk);
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
    b_owed = 1'b0;
  endtask

  task automatic read_tx(input axi_pkg::addr_t addr, input int max_stall);
    int stall;
    stall     = next_rand() % (max_stall + 1);
    exp_rdata = addr_ok(addr) ? model[addr[DEPTH_LOG2+1:2]] : '0;  // out of range reads zero
    exp_rresp = addr_ok(addr) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
    r_owed    = 1'b1;
    araddr    = addr;
    arvalid   = 1'b1;
    while (!arready) @(negedge aclk);
    @(negedge aclk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge aclk);
    repeat (stall) @(negedge aclk);
    rready = 1'b1;
    @(negedge aclk);
    rready = 1'b0;
    r_owed = 1'b0;
  endtask

  task automatic end_test(input string name);
    if (total_errors() == err_mark) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, total_errors() - err_mark);
    end
    err_mark = total_errors();
  endtask

  initial begin
    axi_pkg::addr_t a;
    logic [31:0]    r;
    repeat (2) @(negedge aclk);
    areset = 1'b0;
    repeat (3) @(negedge aclk);
    end_test("reset");
    for (int i = 0; i < 8; i++) begin
      a = (next_rand() & 32'hff) << 2;
      write_tx(a, next_rand(), 4'hf, 0, 0, 0);
      read_tx(a, 0);
      known.push_back(a);
    end
    end_test("full write and read back");
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      write_tx(known[i], next_rand(), r[3:0], 0, 0, 1);
      read_tx(known[i], 1);
    end
    end_test("partial strobe");
    for (int i = 0; i < 8; i++) begin
      a = known[next_rand() % 8];
      r = next_rand();
      write_tx(a, next_rand(), r[3:0], 0, 0, 7);
      read_tx(a, 7);
    end
    end_test("response back-pressure");
    write_tx(known[0], next_rand(), 4'hf, 0, 4, 2);  // AW leads
    read_tx(known[0], 0);
    write_tx(known[1], next_rand(), 4'hf, 4, 0, 2);  // W leads
    read_tx(known[1], 0);
    end_test("aw and w order");
    a = (next_rand() << 10) | 32'h400 | known[2];  // aliases a written word
    write_tx(a, next_rand(), 4'hf, 0, 0, 0);
    read_tx(a, 0);
    read_tx(known[2], 0);
    end_test("out of range");
    repeat (2) @(negedge aclk);
    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0 && total_errors() == 0) $display("TESTBENCH PASSED");
    else $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
common/axi_pkg.sv
common/sram_pkg.sv
common/sram_if.sv
logic/axi_req_front.sv
logic/sram_core.sv
logic/axi_resp_back.sv
logic/axi_sram_top.sv
verif/axi_sram_sva.sv
verif/axi_sram_tb.sv

/* Bender.yml */
package:
  name: axi_sram

sources:
  - files:
      - common/axi_pkg.sv
      - common/sram_pkg.sv
      - common/sram_if.sv
      - logic/axi_req_front.sv
      - logic/sram_core.sv
      - logic/axi_resp_back.sv
      - logic/axi_sram_top.sv
  - target: test
    files:
      - verif/axi_sram_sva.sv
      - verif/axi_sram_tb.sv
